// ==== hw/bank_queues.sv ====
`timescale 1ns/100ps
`include "sched_params.svh"

module bank_queues
    import sched_pkg::*;
(
    input  logic                                 clk_in,
    input  logic                                 rst_in,
    input  logic                                 dec_valid,
    input  sched_req_t                           dec_req,
    input  logic [`SCHED_BANKS-1:0]              pop,
    output logic [`SCHED_BANKS-1:0]              head_valid,
    output sched_req_t [`SCHED_BANKS-1:0]        head_req
);

    localparam int PTR_BITS = (`SCHED_QUEUE_DEPTH > 1) ? $clog2(`SCHED_QUEUE_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(`SCHED_QUEUE_DEPTH + 1);

    // pointer advance with wrap, depth need not be a power of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        logic [PTR_BITS-1:0] nxt;
        if (ptr == PTR_BITS'(`SCHED_QUEUE_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    for (genvar b = 0; b < `SCHED_BANKS; b++) begin : g_bank
        sched_req_t            mem [`SCHED_QUEUE_DEPTH];
        logic [PTR_BITS-1:0]   rd_ptr;
        logic [PTR_BITS-1:0]   wr_ptr;
        logic [CNT_BITS-1:0]   count;
        logic                  push;

        assign push = dec_valid && (dec_req.bank == `SCHED_BANK_BITS'(b));

        always_ff @(posedge clk_in) begin
            if (push) begin
                mem[wr_ptr] <= dec_req;
            end
        end

        always_ff @(posedge clk_in or posedge rst_in) begin
            if (rst_in) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= next_ptr(wr_ptr);
                end
                if (pop[b]) begin
                    rd_ptr <= next_ptr(rd_ptr);
                end
                // simultaneous push and pop leave the count alone
                case ({push, pop[b]})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        assign head_valid[b] = (count != '0);
        assign head_req[b]   = mem[rd_ptr];   // don't care while empty
    end

endmodule

// ==== hw/bank_state_table.sv ====
`timescale 1ns/100ps
`include "sched_params.svh"

module bank_state_table
    import sched_pkg::*;
(
    input  logic                             clk_in,
    input  logic                             rst_in,
    input  logic [`SCHED_BANKS-1:0]          do_activate,
    input  logic [`SCHED_BANKS-1:0]          do_precharge,
    input  logic [`SCHED_ROW_BITS-1:0]       act_row,
    output bank_status_t [`SCHED_BANKS-1:0]  bank_status
);

    localparam int MAX_LAT  = (`SCHED_ACT_LATENCY > `SCHED_PRE_LATENCY) ?
                              `SCHED_ACT_LATENCY : `SCHED_PRE_LATENCY;
    localparam int TMR_BITS = $clog2(MAX_LAT + 1);

    logic [TMR_BITS-1:0]          timer [`SCHED_BANKS];
    logic [`SCHED_BANKS-1:0]      open_q;
    logic [`SCHED_ROW_BITS-1:0]   row_q [`SCHED_BANKS];

    // countdown is loaded at the strobe edge, the bank reads busy while nonzero
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            open_q <= '0;
            for (int b = 0; b < `SCHED_BANKS; b++) begin
                timer[b] <= '0;
            end
        end else begin
            for (int b = 0; b < `SCHED_BANKS; b++) begin
                if (do_activate[b]) begin
                    open_q[b] <= 1'b1;
                    timer[b]  <= TMR_BITS'(`SCHED_ACT_LATENCY);
                end else if (do_precharge[b]) begin
                    open_q[b] <= 1'b0;
                    timer[b]  <= TMR_BITS'(`SCHED_PRE_LATENCY);
                end else if (timer[b] != '0) begin
                    timer[b] <= timer[b] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        for (int b = 0; b < `SCHED_BANKS; b++) begin
            if (do_activate[b]) begin
                row_q[b] <= act_row;   // row latched with the activate
            end
        end
    end

    always_comb begin
        for (int b = 0; b < `SCHED_BANKS; b++) begin
            bank_status[b].open = open_q[b];
            bank_status[b].row  = row_q[b];
            bank_status[b].busy = (timer[b] != '0);
        end
    end

endmodule

// ==== hw/command_arbiter.sv ====
`timescale 1ns/100ps
`include "sched_params.svh"

module command_arbiter
    import sched_pkg::*;
(
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic                           cmd_ready,
    input  logic [`SCHED_BANKS-1:0]        head_valid,
    input  sched_req_t [`SCHED_BANKS-1:0]  head_req,
    output logic [`SCHED_BANKS-1:0]        pop,
    output logic                           cmd_valid,
    output dram_cmd_t                      cmd_out
);

    localparam int BG_BITS  = $clog2(`SCHED_BANK_GROUPS);
    localparam int BA_BITS  = $clog2(`SCHED_BANKS_PER_GROUP);
    localparam int GAP_BITS = $clog2(`SCHED_BURST_GAP + 1);

    bank_status_t [`SCHED_BANKS-1:0]  bank_status;
    cmd_kind_e                        need_kind [`SCHED_BANKS];
    logic [`SCHED_BANKS-1:0]          is_col;
    logic [`SCHED_BANKS-1:0]          eligible;
    logic [`SCHED_BANKS-1:0]          do_activate;
    logic [`SCHED_BANKS-1:0]          do_precharge;
    logic [GAP_BITS-1:0]              gap_cnt;
    logic                             gap_ok;
    logic                             sel_valid;
    logic                             win;
    logic [`SCHED_BANK_BITS-1:0]      sel_bank;
    sched_req_t                       sel_req;
    cmd_kind_e                        sel_kind;
    logic                             sel_is_col;
    dram_cmd_t                        next_cmd;

    bank_state_table i_bank_state_table (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .do_activate  (do_activate),
        .do_precharge (do_precharge),
        .act_row      (sel_req.row),
        .bank_status  (bank_status)
    );

    // command each head needs given the bank's open row
    always_comb begin
        for (int b = 0; b < `SCHED_BANKS; b++) begin
            if (!bank_status[b].open) begin
                need_kind[b] = CMD_ACTIVATE;
            end else if (bank_status[b].row != head_req[b].row) begin
                need_kind[b] = CMD_PRECHARGE;   // row miss
            end else if (head_req[b].write) begin
                need_kind[b] = CMD_WRITE;
            end else begin
                need_kind[b] = CMD_READ;
            end
            is_col[b]   = (need_kind[b] == CMD_READ) || (need_kind[b] == CMD_WRITE);
            eligible[b] = head_valid[b] && !bank_status[b].busy && (!is_col[b] || gap_ok);
        end
    end

    // descending scan so the lowest eligible bank wins
    always_comb begin
        sel_valid = 1'b0;
        sel_bank  = '0;
        for (int b = `SCHED_BANKS - 1; b >= 0; b--) begin
            if (eligible[b]) begin
                sel_valid = 1'b1;
                sel_bank  = `SCHED_BANK_BITS'(b);
            end
        end
    end

    assign sel_req    = head_req[sel_bank];
    assign sel_kind   = need_kind[sel_bank];
    assign sel_is_col = is_col[sel_bank];
    assign win        = cmd_ready && sel_valid;

    always_comb begin
        next_cmd.kind       = sel_kind;
        next_cmd.bank_group = BG_BITS'(sel_bank / `SCHED_BANKS_PER_GROUP);
        next_cmd.bank       = BA_BITS'(sel_bank % `SCHED_BANKS_PER_GROUP);
        next_cmd.data       = (sel_kind == CMD_WRITE) ? sel_req.data : '0;
        if (sel_kind == CMD_ACTIVATE) begin
            next_cmd.addr.row_view.pad = '0;
            next_cmd.addr.row_view.row = sel_req.row;
        end else begin
            case (sel_kind)
                CMD_READ:  next_cmd.addr.col_view.op = `SCHED_OP_READ;
                CMD_WRITE: next_cmd.addr.col_view.op = `SCHED_OP_WRITE;
                default:   next_cmd.addr.col_view.op = `SCHED_OP_PRECHARGE;
            endcase
            next_cmd.addr.col_view.pad = '0;
            next_cmd.addr.col_view.col = sel_req.col;
        end
    end

    // strobes act at the slot edge, so the next cycle sees the new state
    always_comb begin
        pop          = '0;
        do_activate  = '0;
        do_precharge = '0;
        if (win) begin
            case (sel_kind)
                CMD_ACTIVATE:  do_activate[sel_bank]  = 1'b1;
                CMD_PRECHARGE: do_precharge[sel_bank] = 1'b1;
                default:       pop[sel_bank]          = 1'b1;   // access retires the head
            endcase
        end
    end

    assign gap_ok = (gap_cnt == '0);

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            cmd_valid <= 1'b0;
            gap_cnt   <= '0;
        end else begin
            cmd_valid <= win;
            if (win && sel_is_col) begin
                gap_cnt <= GAP_BITS'(`SCHED_BURST_GAP - 1);
            end else if (!gap_ok) begin
                gap_cnt <= gap_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (win) begin
            cmd_out <= next_cmd;
        end
    end

endmodule

// ==== hw/request_decoder.sv ====
`timescale 1ns/100ps
`include "sched_params.svh"

module request_decoder
    import sched_pkg::*;
(
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  logic                          req_valid,
    input  logic [`SCHED_ADDR_BITS-1:0]   req_addr,
    input  logic                          req_write,
    input  logic [`SCHED_DATA_BITS-1:0]   req_data,
    output logic                          dec_valid,
    output sched_req_t                    dec_req
);

    localparam int BG_BITS = $clog2(`SCHED_BANK_GROUPS);
    localparam int BA_BITS = $clog2(`SCHED_BANKS_PER_GROUP);

    logic [`SCHED_COL_BITS-1:0]   col;
    logic [BA_BITS-1:0]           ba;
    logic [BG_BITS-1:0]           bg;
    logic [`SCHED_ROW_BITS-1:0]   row;
    logic [`SCHED_BANK_BITS-1:0]  flat_bank;

    assign col = req_addr[`SCHED_COL_BITS-1:0];
    assign ba  = req_addr[`SCHED_COL_BITS +: BA_BITS];
    assign bg  = req_addr[`SCHED_COL_BITS+BA_BITS +: BG_BITS];
    assign row = req_addr[`SCHED_ADDR_BITS-1 -: `SCHED_ROW_BITS];

    // group * banks per group + bank
    assign flat_bank = `SCHED_BANK_BITS'(bg) * `SCHED_BANK_BITS'(`SCHED_BANKS_PER_GROUP)
                     + `SCHED_BANK_BITS'(ba);

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        if (req_valid) begin
            dec_req <= '{write: req_write, bank: flat_bank, row: row, col: col, data: req_data};
        end
    end

endmodule

// ==== hw/request_scheduler.sv ====
`timescale 1ns/100ps
`include "sched_params.svh"

module request_scheduler
    import sched_pkg::*;
(
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  logic                          req_valid,
    input  logic [`SCHED_ADDR_BITS-1:0]   req_addr,
    input  logic                          req_write,
    input  logic [`SCHED_DATA_BITS-1:0]   req_data,
    input  logic                          cmd_ready,
    output logic                          cmd_valid,
    output dram_cmd_t                     cmd_out
);

    logic                            dec_valid;
    sched_req_t                      dec_req;
    logic [`SCHED_BANKS-1:0]         head_valid;
    sched_req_t [`SCHED_BANKS-1:0]   head_req;
    logic [`SCHED_BANKS-1:0]         pop;

    request_decoder i_request_decoder (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_write (req_write),
        .req_data  (req_data),
        .dec_valid (dec_valid),
        .dec_req   (dec_req)
    );

    // in-order queue per bank
    bank_queues i_bank_queues (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .dec_valid  (dec_valid),
        .dec_req    (dec_req),
        .pop        (pop),
        .head_valid (head_valid),
        .head_req   (head_req)
    );

    command_arbiter i_command_arbiter (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .cmd_ready  (cmd_ready),
        .head_valid (head_valid),
        .head_req   (head_req),
        .pop        (pop),
        .cmd_valid  (cmd_valid),
        .cmd_out    (cmd_out)
    );

endmodule

// ==== hw/sched_params.svh ====
`ifndef SCHED_PARAMS_SVH
`define SCHED_PARAMS_SVH

// bank geometry
`define SCHED_BANK_GROUPS       2
`define SCHED_BANKS_PER_GROUP   2
`define SCHED_BANKS             4
`define SCHED_BANK_BITS         2

// bus address is {row, bank group, bank, column}
`define SCHED_ROW_BITS          8
`define SCHED_COL_BITS          4
`define SCHED_ADDR_BITS         14
`define SCHED_DATA_BITS         32

`define SCHED_QUEUE_DEPTH       4   // entries per bank

// timing in clock cycles
`define SCHED_ACT_LATENCY       8
`define SCHED_PRE_LATENCY       5
`define SCHED_BURST_GAP         4   // spacing of read/write commands

// opcodes for the column view of the command address
`define SCHED_OP_READ           3'b101
`define SCHED_OP_WRITE          3'b100
`define SCHED_OP_PRECHARGE      3'b010

`endif

// ==== hw/sched_pkg.sv ====
`include "sched_params.svh"

package sched_pkg;

    typedef enum logic [1:0] {
        CMD_READ      = 2'd0,
        CMD_WRITE     = 2'd1,
        CMD_ACTIVATE  = 2'd2,
        CMD_PRECHARGE = 2'd3
    } cmd_kind_e;

    // request after address split, bank is the flat index
    typedef struct packed {
        logic                          write;
        logic [`SCHED_BANK_BITS-1:0]   bank;
        logic [`SCHED_ROW_BITS-1:0]    row;
        logic [`SCHED_COL_BITS-1:0]    col;
        logic [`SCHED_DATA_BITS-1:0]   data;
    } sched_req_t;

    // activate carries the row in the low bits
    typedef struct packed {
        logic [`SCHED_ADDR_BITS-`SCHED_ROW_BITS-1:0]   pad;
        logic [`SCHED_ROW_BITS-1:0]                    row;
    } cmd_row_view_t;

    // read, write and precharge carry opcode on top and column below
    typedef struct packed {
        logic [2:0]                                    op;
        logic [`SCHED_ADDR_BITS-3-`SCHED_COL_BITS-1:0] pad;
        logic [`SCHED_COL_BITS-1:0]                    col;
    } cmd_col_view_t;

    typedef union packed {
        cmd_row_view_t row_view;
        cmd_col_view_t col_view;
    } cmd_addr_u;

    typedef struct packed {
        cmd_kind_e                                  kind;
        logic [$clog2(`SCHED_BANK_GROUPS)-1:0]      bank_group;
        logic [$clog2(`SCHED_BANKS_PER_GROUP)-1:0]  bank;
        cmd_addr_u                                  addr;
        logic [`SCHED_DATA_BITS-1:0]                data;  // zero unless write
    } dram_cmd_t;

    typedef struct packed {
        logic                        open;
        logic [`SCHED_ROW_BITS-1:0]  row;   // meaningful only when open
        logic                        busy;
    } bank_status_t;

endpackage

// ==== request_scheduler.f ====
+incdir+hw
hw/sched_pkg.sv
hw/request_decoder.sv
hw/bank_queues.sv
hw/bank_state_table.sv
hw/command_arbiter.sv
hw/request_scheduler.sv
tb/tb_request_scheduler.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the scheduler testbench with Verilator, the log decides the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f request_scheduler.f \
    --top-module tb_request_scheduler -Mdir obj_dir > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_request_scheduler > sim.log 2>&1
grep -q "Test failures found" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "simulation did not finish, see sim.log"; exit 1; }
echo "simulation passed"

// ==== tb/tb_request_scheduler.sv ====
`timescale 1ns/100ps
`include "sched_params.svh"

module tb_request_scheduler
    import sched_pkg::*;
();

    localparam int NUM_REQ  = 200;
    localparam int CLK_HALF = 4;    // 8 ns period

    logic                          clk_in;
    logic                          rst_in;
    logic                          req_valid;
    logic [`SCHED_ADDR_BITS-1:0]   req_addr;
    logic                          req_write;
    logic [`SCHED_DATA_BITS-1:0]   req_data;
    logic                          cmd_ready;
    logic                          cmd_valid;
    dram_cmd_t                     cmd_out;

    sched_req_t                    exp_q [`SCHED_BANKS][$];   // pending requests in arrival order
    logic                          m_open [`SCHED_BANKS];
    logic [`SCHED_ROW_BITS-1:0]    m_row [`SCHED_BANKS];
    int                            last_act [`SCHED_BANKS];
    int                            last_pre [`SCHED_BANKS];
    int                            last_col;
    int                            cycle;
    int                            sent;
    int                            served;

    request_scheduler i_request_scheduler (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_write (req_write),
        .req_data  (req_data),
        .cmd_ready (cmd_ready),
        .cmd_valid (cmd_valid),
        .cmd_out   (cmd_out)
    );

    always #CLK_HALF clk_in = ~clk_in;

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("FAIL at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    // a command only follows a cycle that offered a slot
    assert property (@(posedge clk_in) disable iff (rst_in) cmd_valid |-> $past(cmd_ready))
        else report_mismatch("cmd_valid", 64'd1, 64'd0);

    task automatic check_command();
        int          b;
        sched_req_t  head;
        cmd_kind_e   exp_kind;
        b = int'(cmd_out.bank_group) * `SCHED_BANKS_PER_GROUP + int'(cmd_out.bank);
        if (exp_q[b].size() == 0) begin
            report_error($sformatf("command for bank %0d with no pending request", b));
        end else begin
            head = exp_q[b][0];
            case (cmd_out.kind)
                CMD_ACTIVATE: begin
                    assert (!m_open[b]) else report_error("activate to a bank already open");
                    assert (cmd_out.addr.row_view.row == head.row)
                        else report_mismatch("cmd_out.addr.row_view.row",
                                             64'(cmd_out.addr.row_view.row), 64'(head.row));
                    assert (cmd_out.addr.row_view.pad == '0)
                        else report_mismatch("cmd_out.addr.row_view.pad",
                                             64'(cmd_out.addr.row_view.pad), 64'd0);
                    assert (cycle - last_pre[b] >= `SCHED_PRE_LATENCY)
                        else report_error("activate while the bank is still precharging");
                    m_open[b]   = 1'b1;
                    m_row[b]    = head.row;
                    last_act[b] = cycle;
                end
                CMD_PRECHARGE: begin
                    assert (m_open[b] && m_row[b] != head.row)
                        else report_error("precharge without a row miss");
                    assert (cmd_out.addr.col_view.op == `SCHED_OP_PRECHARGE)
                        else report_mismatch("cmd_out.addr.col_view.op",
                                             64'(cmd_out.addr.col_view.op),
                                             64'(`SCHED_OP_PRECHARGE));
                    assert (cmd_out.addr.col_view.pad == '0)
                        else report_mismatch("cmd_out.addr.col_view.pad",
                                             64'(cmd_out.addr.col_view.pad), 64'd0);
                    assert (cmd_out.addr.col_view.col == head.col)
                        else report_mismatch("cmd_out.addr.col_view.col",
                                             64'(cmd_out.addr.col_view.col), 64'(head.col));
                    assert (cycle - last_act[b] >= `SCHED_ACT_LATENCY)
                        else report_error("precharge while the bank is still activating");
                    m_open[b]   = 1'b0;
                    last_pre[b] = cycle;
                end
                default: begin
                    exp_kind = head.write ? CMD_WRITE : CMD_READ;
                    assert (cmd_out.kind == exp_kind)
                        else report_mismatch("cmd_out.kind", 64'(cmd_out.kind), 64'(exp_kind));
                    assert (m_open[b] && m_row[b] == head.row)
                        else report_error("access to a bank not open on the request's row");
                    assert (cmd_out.addr.col_view.op ==
                            (head.write ? `SCHED_OP_WRITE : `SCHED_OP_READ))
                        else report_mismatch("cmd_out.addr.col_view.op",
                                             64'(cmd_out.addr.col_view.op),
                                             head.write ? 64'(`SCHED_OP_WRITE)
                                                        : 64'(`SCHED_OP_READ));
                    assert (cmd_out.addr.col_view.pad == '0)
                        else report_mismatch("cmd_out.addr.col_view.pad",
                                             64'(cmd_out.addr.col_view.pad), 64'd0);
                    assert (cmd_out.addr.col_view.col == head.col)
                        else report_mismatch("cmd_out.addr.col_view.col",
                                             64'(cmd_out.addr.col_view.col), 64'(head.col));
                    if (head.write) begin
                        assert (cmd_out.data == head.data)
                            else report_mismatch("cmd_out.data", 64'(cmd_out.data),
                                                 64'(head.data));
                    end
                    assert (cycle - last_act[b] >= `SCHED_ACT_LATENCY)
                        else report_error("access before the activate latency elapsed");
                    assert (cycle - last_col >= `SCHED_BURST_GAP)
                        else report_error("two column commands closer than the burst gap");
                    last_col = cycle;
                    void'(exp_q[b].pop_front());
                    served++;
                end
            endcase
        end
    endtask

    task automatic drive_inputs();
        logic [`SCHED_BANK_BITS-1:0]  bank;
        sched_req_t                   req;
        cmd_ready = ($urandom_range(0, 99) < 60);
        req_valid = 1'b0;
        bank      = `SCHED_BANK_BITS'($urandom_range(0, `SCHED_BANKS - 1));
        if (sent < NUM_REQ && $urandom_range(0, 99) < 40
                && exp_q[bank].size() < `SCHED_QUEUE_DEPTH) begin
            req.write = 1'($urandom_range(0, 1));
            req.bank  = bank;
            req.row   = `SCHED_ROW_BITS'($urandom_range(0, 2) * 37);   // three rows give hits and misses
            req.col   = `SCHED_COL_BITS'($urandom_range(0, (1 << `SCHED_COL_BITS) - 1));
            req.data  = $urandom;
            req_valid = 1'b1;
            req_addr  = {req.row, bank, req.col};   // group and bank bits form the flat index
            req_write = req.write;
            req_data  = req.data;
            exp_q[bank].push_back(req);
            sent++;
        end
    endtask

    task automatic step_cycle();
        cycle++;
        assert (sent > 0 || !cmd_valid) else report_mismatch("cmd_valid", 64'd1, 64'd0);
        if (cmd_valid) begin
            check_command();
        end
        drive_inputs();
    endtask

    initial begin
        void'($urandom(60161));
        clk_in    = 1'b0;
        rst_in    = 1'b1;
        req_valid = 1'b0;
        req_addr  = '0;
        req_write = 1'b0;
        req_data  = '0;
        cmd_ready = 1'b0;
        cycle     = 0;
        sent      = 0;
        served    = 0;
        last_col  = -1000;
        for (int b = 0; b < `SCHED_BANKS; b++) begin
            m_open[b]   = 1'b0;
            m_row[b]    = '0;
            last_act[b] = -1000;
            last_pre[b] = -1000;
        end
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;
        while (!(sent == NUM_REQ && served == NUM_REQ)) begin
            @(negedge clk_in);
            step_cycle();
        end
        // idle tail where a stray command finds no pending request
        repeat (20) begin
            @(negedge clk_in);
            step_cycle();
        end
        $display("All tests passed!");
        $finish;
    end

    initial begin
        repeat (NUM_REQ * 60) @(posedge clk_in);
        $display("Timeout: requests were not all served within %0d cycles", NUM_REQ * 60);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

endmodule
